/* Makefile */
SIM := obj_dir/trap_unit_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the trap unit testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --assert -f build.f --top-module trap_unit_tb -o trap_unit_sim
	./$(SIM) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* build.f */
logic/trap_pkg.sv
logic/trap_state_if.sv
logic/irq_select.sv
logic/trap_ctrl.sv
logic/csr_regs.sv
logic/trap_unit.sv
dv/trap_unit_checker.sv
dv/trap_unit_tb.sv

/* dv/trap_unit_checker.sv */
// trap unit protocol checker: output rules of the top level, attached by bind.
module trap_unit_checker import trap_pkg::*; (
    input logic  clk,
    input logic  srstn,
    input logic  int_mask,
    input logic  trap_en,
    input logic  irq_trigger,
    input logic  eret_en,
    input logic  wakeup,
    input priv_t prv,
    input xlen_t trap_vec
);

// an exception always wins over an interrupt.
no_irq_with_trap: assert property (@(posedge clk) disable iff (~srstn)
    !(irq_trigger && trap_en))
    else $error("irq_trigger and trap_en are high in the same cycle");

no_eret_with_trap: assert property (@(posedge clk) disable iff (~srstn)
    !(eret_en && trap_en))
    else $error("eret_en and trap_en are high in the same cycle");

legal_prv: assert property (@(posedge clk) disable iff (~srstn)
    (prv == PRV_U) || (prv == PRV_M))
    else $error("prv holds a level other than user or machine");

vec_aligned: assert property (@(posedge clk) disable iff (~srstn)
    trap_vec[1:0] == 2'b00)
    else $error("trap_vec is not word aligned");

trigger_wakes: assert property (@(posedge clk) disable iff (~srstn)
    irq_trigger |-> (wakeup && !int_mask))
    else $error("irq_trigger is high without wakeup or while int_mask is set");

endmodule

bind trap_unit trap_unit_checker trap_unit_checker_i (
    .clk         (clk),
    .srstn       (srstn),
    .int_mask    (int_mask),
    .trap_en     (trap_en),
    .irq_trigger (irq_trigger),
    .eret_en     (eret_en),
    .wakeup      (wakeup),
    .prv         (prv),
    .trap_vec    (trap_vec)
);

/* dv/trap_unit_tb.sv */
// trap unit testbench: CSR read-back, exceptions, vectored interrupts, masking and mret.
module trap_unit_tb import trap_pkg::*; ();

localparam int NUM_TESTS   = 5;
localparam int TEST_CYCLES = 200;
localparam int CLK_PERIOD  = 100;

logic      clk;
logic      srstn;
logic      ext_msip;
logic      ext_mtip;
logic      ext_meip;
logic      int_mask;
logic      trap_en;
xlen_t     trap_epc;
xlen_t     trap_cause;
xlen_t     trap_val;
logic      mret;
logic      csr_wr;
csr_addr_t csr_waddr;
xlen_t     csr_wdata;
csr_addr_t csr_raddr;
xlen_t     csr_rdata;
priv_t     prv;
logic      irq_trigger;
logic      wakeup;
xlen_t     cause;
xlen_t     tval;
xlen_t     trap_vec;
xlen_t     ret_epc;
logic      eret_en;

string       test_name;
int          test_errors;
int          errors;
int          tests_run;
int          tests_failed;
logic [31:0] lfsr = 32'd22;

trap_unit trap_unit_i (.*);

always #(CLK_PERIOD / 2) clk = ~clk;

initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
end

// galois lfsr with taps at x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic random_word(output xlen_t w);
    for (int i = 0; i < XLEN; i++) begin
        lfsr = lfsr_next(lfsr);
        w[i] = lfsr[0];
    end
endtask

// inputs change a little after the rising edge.
task automatic tick();
    @(posedge clk);
    #10;
endtask

task automatic check(input string what, input xlen_t exp, input xlen_t act);
    assert (act === exp) else begin
        $display("error %s: %s expected %h, actual %h", test_name, what, exp, act);
        test_errors++;
    end
endtask

task automatic csr_write(input csr_addr_t addr, input xlen_t data);
    csr_wr    = 1'b1;
    csr_waddr = addr;
    csr_wdata = data;
    tick();
    csr_wr    = 1'b0;
endtask

task automatic expect_csr(input string what, input csr_addr_t addr, input xlen_t exp);
    csr_raddr = addr;
    #1;
    check(what, exp, csr_rdata);
endtask

task automatic wait_trigger(input int max_cycles);
    int n;
    n = 0;
    while (!irq_trigger && n < max_cycles) begin
        tick();
        n++;
    end
    assert (irq_trigger) else begin
        $display("%s: no interrupt was taken within %0d cycles", test_name, max_cycles);
        test_errors++;
    end
endtask

task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
endtask

task automatic end_test();
    if (test_errors == 0) begin
        $display("test %s: ok", test_name);
    end
    else begin
        $display("test %s: %0d errors", test_name, test_errors);
        tests_failed++;
    end
    errors += test_errors;
    tests_run++;
endtask

initial begin
    xlen_t w;
    clk        = 1'b0;
    srstn      = 1'b0;
    ext_msip   = 1'b0;
    ext_mtip   = 1'b0;
    ext_meip   = 1'b0;
    int_mask   = 1'b0;
    trap_en    = 1'b0;
    trap_epc   = '0;
    trap_cause = '0;
    trap_val   = '0;
    mret       = 1'b0;
    csr_wr     = 1'b0;
    csr_waddr  = '0;
    csr_wdata  = '0;
    csr_raddr  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #10;
    srstn = 1'b1;
    tick();

    begin_test("csr_readback");
    repeat (2) begin
        random_word(w);
        csr_write(CSR_MSCRATCH, w);
        expect_csr("mscratch", CSR_MSCRATCH, w);
    end
    csr_write(CSR_MTVEC, 32'h8000_0107);
    expect_csr("mtvec", CSR_MTVEC, 32'h8000_0105);
    random_word(w);
    csr_write(CSR_MEPC, w);
    expect_csr("mepc", CSR_MEPC, w & 32'hFFFF_FFFE);
    csr_write(CSR_MIE, 32'hFFFF_FFFF);
    expect_csr("mie", CSR_MIE, 32'h0000_0888);
    expect_csr("unmapped", 12'h7C0, 32'h0);
    csr_write(CSR_MIE, 32'h0);
    end_test();

    begin_test("exception");
    csr_write(CSR_MTVEC, 32'h0000_1001);
    csr_write(CSR_MIE, 32'h0000_0008);
    ext_msip = 1'b1;
    repeat (2) tick();
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    // the exception outranks a pending interrupt and an mret.
    trap_en    = 1'b1;
    mret       = 1'b1;
    trap_epc   = 32'h2000_0104;
    trap_cause = 32'd2;
    trap_val   = 32'hDEAD_BEEF;
    #1;
    check("trap_vec", 32'h0000_1000, trap_vec);
    check("cause", 32'd2, cause);
    check("tval", 32'hDEAD_BEEF, tval);
    check("irq_trigger", 32'd0, 32'(irq_trigger));
    check("eret_en", 32'd0, 32'(eret_en));
    tick();
    trap_en  = 1'b0;
    mret     = 1'b0;
    ext_msip = 1'b0;
    expect_csr("mepc", CSR_MEPC, 32'h2000_0104);
    expect_csr("mcause", CSR_MCAUSE, 32'd2);
    expect_csr("mtval", CSR_MTVAL, 32'hDEAD_BEEF);
    // mie 0, mpie 1, mpp machine.
    expect_csr("mstatus", CSR_MSTATUS, 32'h0000_1880);
    csr_write(CSR_MIE, 32'h0);
    end_test();

    begin_test("vectored_irq");
    csr_write(CSR_MTVEC, 32'h0000_2001);
    csr_write(CSR_MIE, 32'h0000_0080);
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    trap_epc = 32'h2000_0200;
    ext_mtip = 1'b1;
    wait_trigger(4);
    check("cause", 32'h8000_0007, cause);
    check("trap_vec", 32'h0000_201C, trap_vec);
    tick();
    check("irq_trigger pulse", 32'd0, 32'(irq_trigger));
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_0007);
    expect_csr("mepc", CSR_MEPC, 32'h2000_0200);
    expect_csr("mtval", CSR_MTVAL, 32'h0);
    ext_msip = 1'b1;
    ext_meip = 1'b1;
    csr_write(CSR_MIE, 32'h0000_0888);
    repeat (2) tick();
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    wait_trigger(4);
    check("cause", 32'h8000_000B, cause);
    check("trap_vec", 32'h0000_202C, trap_vec);
    tick();
    ext_msip = 1'b0;
    ext_mtip = 1'b0;
    ext_meip = 1'b0;
    repeat (3) tick();
    end_test();

    begin_test("masking");
    csr_write(CSR_MIE, 32'h0000_0080);
    int_mask = 1'b1;
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    ext_mtip = 1'b1;
    repeat (4) begin
        tick();
        check("irq_trigger masked", 32'd0, 32'(irq_trigger));
    end
    check("wakeup", 32'd1, 32'(wakeup));
    csr_write(CSR_MSTATUS, 32'h0);
    int_mask = 1'b0;
    repeat (2) begin
        tick();
        check("irq_trigger mie off", 32'd0, 32'(irq_trigger));
    end
    check("wakeup", 32'd1, 32'(wakeup));
    ext_mtip = 1'b0;
    repeat (3) tick();
    end_test();

    begin_test("mret_user");
    // a reserved mpp level is stored as user.
    csr_write(CSR_MSTATUS, 32'h0000_1000);
    expect_csr("mstatus mpp", CSR_MSTATUS, 32'h0);
    random_word(w);
    csr_write(CSR_MEPC, w);
    mret = 1'b1;
    #1;
    check("eret_en", 32'd1, 32'(eret_en));
    check("ret_epc", w & 32'hFFFF_FFFE, ret_epc);
    tick();
    mret = 1'b0;
    #1;
    check("eret_en", 32'd0, 32'(eret_en));
    check("prv", 32'd0, 32'(prv));
    expect_csr("mstatus", CSR_MSTATUS, 32'h0000_0080);
    // user mode takes the interrupt although mie is 0.
    csr_write(CSR_MIE, 32'h0000_0008);
    ext_msip = 1'b1;
    wait_trigger(4);
    check("cause", 32'h8000_0003, cause);
    tick();
    check("prv", 32'd3, 32'(prv));
    expect_csr("mstatus", CSR_MSTATUS, 32'h0);
    ext_msip = 1'b0;
    repeat (3) tick();
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("*** TEST PASSED ***");
    end
    else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

/* logic/csr_regs.sv */
// machine CSR block: mie, mtvec and mscratch storage plus the CSR read mux.
module csr_regs import trap_pkg::*; (
    input  logic         clk,
    input  logic         srstn,
    input  logic         csr_wr,
    input  csr_addr_t    csr_waddr,
    input  xlen_t        csr_wdata,
    input  csr_addr_t    csr_raddr,
    input  logic [2:0]   mip_pend,
    trap_state_if.sink   state,
    output logic [2:0]   mie_en,
    output xlen_t        mtvec,
    output xlen_t        csr_rdata
);

xlen_t mscratch;
xlen_t mstatus_rd;
xlen_t mie_rd;
xlen_t mip_rd;

// enable order {mei, mti, msi}, same as the pending lines.
always_ff @(posedge clk or negedge srstn) begin
    if (~srstn) begin
        mie_en   <= '0;
        mtvec    <= '0;
        mscratch <= '0;
    end
    else if (csr_wr) begin
        if (csr_waddr == CSR_MIE) begin
            mie_en <= {csr_wdata[IRQ_MEI], csr_wdata[IRQ_MTI], csr_wdata[IRQ_MSI]};
        end
        // mode values above 1 are reserved.
        if (csr_waddr == CSR_MTVEC) begin
            mtvec <= {csr_wdata[XLEN-1:2], 1'b0, csr_wdata[0]};
        end
        if (csr_waddr == CSR_MSCRATCH) begin
            mscratch <= csr_wdata;
        end
    end
end

always_comb begin
    mstatus_rd                          = '0;
    mstatus_rd[MSTATUS_MIE_BIT]         = state.mstatus_mie;
    mstatus_rd[MSTATUS_MPIE_BIT]        = state.mstatus_mpie;
    mstatus_rd[MSTATUS_MPP_LSB +: 2]    = state.mstatus_mpp;

    mie_rd          = '0;
    mie_rd[IRQ_MSI] = mie_en[0];
    mie_rd[IRQ_MTI] = mie_en[1];
    mie_rd[IRQ_MEI] = mie_en[2];

    mip_rd          = '0;
    mip_rd[IRQ_MSI] = mip_pend[0];
    mip_rd[IRQ_MTI] = mip_pend[1];
    mip_rd[IRQ_MEI] = mip_pend[2];
end

always_comb begin
    case (csr_raddr)
        CSR_MSTATUS:  csr_rdata = mstatus_rd;
        CSR_MIE:      csr_rdata = mie_rd;
        CSR_MIP:      csr_rdata = mip_rd;
        CSR_MTVEC:    csr_rdata = mtvec;
        CSR_MSCRATCH: csr_rdata = mscratch;
        CSR_MEPC:     csr_rdata = state.mepc;
        CSR_MCAUSE:   csr_rdata = state.mcause;
        CSR_MTVAL:    csr_rdata = state.mtval;
        default:      csr_rdata = '0;
    endcase
end

endmodule

/* logic/irq_select.sv */
// interrupt select: synchronizes the machine interrupt lines and resolves their priority.
module irq_select import trap_pkg::*; (
    input  logic                    clk,
    input  logic                    srstn,
    input  logic                    ext_msip,
    input  logic                    ext_mtip,
    input  logic                    ext_meip,
    input  logic [2:0]              mie_en,
    output logic [2:0]              mip_pend,
    output logic [2:0]              irq_m_en,
    output logic                    irq_any,
    output logic [CAUSE_CODE_W-1:0] irq_code,
    output logic                    wakeup
);

// line order in every 3-bit vector is {mei, mti, msi}.
logic [SYNC_STAGES-1:0][2:0] sync_q;

always_ff @(posedge clk or negedge srstn) begin
    if (~srstn) begin
        sync_q <= '0;
    end
    else begin
        sync_q <= {sync_q[SYNC_STAGES-2:0], {ext_meip, ext_mtip, ext_msip}};
    end
end

assign mip_pend = sync_q[SYNC_STAGES-1];
assign irq_m_en = mip_pend & mie_en;
assign irq_any  = |irq_m_en;

// external first, then software, then timer.
always_comb begin
    if (irq_m_en[2]) begin
        irq_code = CAUSE_CODE_W'(IRQ_MEI);
    end
    else if (irq_m_en[0]) begin
        irq_code = CAUSE_CODE_W'(IRQ_MSI);
    end
    else if (irq_m_en[1]) begin
        irq_code = CAUSE_CODE_W'(IRQ_MTI);
    end
    else begin
        irq_code = '0;
    end
end

// wake the core even while the global enable is off.
assign wakeup = irq_any;

endmodule

/* logic/trap_ctrl.sv */
// trap control: privilege and mstatus state, trap entry, interrupt entry and mret.
module trap_ctrl import trap_pkg::*; (
    input  logic                    clk,
    input  logic                    srstn,
    input  logic                    irq_any,
    input  logic [CAUSE_CODE_W-1:0] irq_code,
    input  logic                    int_mask,
    input  logic                    trap_en,
    input  xlen_t                   trap_epc,
    input  xlen_t                   trap_cause,
    input  xlen_t                   trap_val,
    input  logic                    mret,
    input  logic                    csr_wr,
    input  csr_addr_t               csr_waddr,
    input  xlen_t                   csr_wdata,
    input  xlen_t                   mtvec,
    trap_state_if.source            state,
    output logic                    irq_trigger,
    output xlen_t                   cause,
    output xlen_t                   tval,
    output xlen_t                   trap_vec,
    output xlen_t                   ret_epc,
    output logic                    eret_en
);

priv_t                   prv;
logic                    mie;
logic                    mpie;
priv_t                   mpp;
xlen_t                   mepc;
logic                    mcause_int;
logic [CAUSE_CODE_W-1:0] mcause_code;
xlen_t                   mtval;
logic                    int_take;
logic                    wr_mstatus;
priv_t                   wr_mpp;
xlen_t                   vec_offset;

// user mode always takes an enabled interrupt.
assign int_take    = irq_any & ~int_mask & ~trap_en & ((prv == PRV_U) | mie);
assign irq_trigger = int_take;
assign eret_en     = mret & ~trap_en;
assign ret_epc     = mepc;

assign cause = trap_en  ? trap_cause :
               int_take ? {1'b1, {(XLEN-CAUSE_CODE_W-1){1'b0}}, irq_code} :
                          '0;
assign tval  = trap_en ? trap_val : '0;

assign vec_offset = (int_take & mtvec[0]) ?
                    {{(XLEN-CAUSE_CODE_W-2){1'b0}}, irq_code, 2'b00} : '0;
assign trap_vec   = {mtvec[XLEN-1:2], 2'b00} + vec_offset;

assign wr_mstatus = csr_wr && (csr_waddr == CSR_MSTATUS);
// mpp holds only legal levels.
assign wr_mpp     = (csr_wdata[MSTATUS_MPP_LSB +: 2] == PRV_M) ? PRV_M : PRV_U;

always_ff @(posedge clk or negedge srstn) begin
    if (~srstn) begin
        prv  <= PRV_M;
        mie  <= 1'b0;
        mpie <= 1'b0;
        mpp  <= PRV_U;
    end
    else if (trap_en || int_take) begin
        prv  <= PRV_M;
        mpp  <= prv;
        mpie <= mie;
        mie  <= 1'b0;
    end
    else if (mret) begin
        prv  <= mpp;
        mie  <= mpie;
        mpie <= 1'b1;
        mpp  <= PRV_U;
    end
    else if (wr_mstatus) begin
        mie  <= csr_wdata[MSTATUS_MIE_BIT];
        mpie <= csr_wdata[MSTATUS_MPIE_BIT];
        mpp  <= wr_mpp;
    end
end

always_ff @(posedge clk or negedge srstn) begin
    if (~srstn) begin
        mepc        <= '0;
        mcause_int  <= 1'b0;
        mcause_code <= '0;
        mtval       <= '0;
    end
    else if (trap_en) begin
        mepc        <= trap_epc;
        mcause_int  <= trap_cause[XLEN-1];
        mcause_code <= trap_cause[CAUSE_CODE_W-1:0];
        mtval       <= trap_val;
    end
    else if (int_take) begin
        mepc        <= trap_epc;
        mcause_int  <= 1'b1;
        mcause_code <= irq_code;
        mtval       <= '0;
    end
    else if (csr_wr) begin
        if (csr_waddr == CSR_MEPC) begin
            mepc <= {csr_wdata[XLEN-1:1], 1'b0};
        end
        if (csr_waddr == CSR_MCAUSE) begin
            mcause_int  <= csr_wdata[XLEN-1];
            mcause_code <= csr_wdata[CAUSE_CODE_W-1:0];
        end
        if (csr_waddr == CSR_MTVAL) begin
            mtval <= csr_wdata;
        end
    end
end

assign state.prv          = prv;
assign state.mstatus_mie  = mie;
assign state.mstatus_mpie = mpie;
assign state.mstatus_mpp  = mpp;
assign state.mepc         = mepc;
assign state.mcause       = {mcause_int, {(XLEN-CAUSE_CODE_W-1){1'b0}}, mcause_code};
assign state.mtval        = mtval;

endmodule

/* logic/trap_pkg.sv */
// trap unit package: data widths, machine CSR addresses, bit positions and cause codes.
package trap_pkg;

    // data path.
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [1:0]      priv_t;

    // privilege levels, only user and machine exist.
    localparam priv_t PRV_U = 2'd0;
    localparam priv_t PRV_M = 2'd3;

    // machine trap setup.
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    // machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // bit position in mie/mip, equal to the interrupt cause code.
    localparam int IRQ_MSI = 3;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_MEI = 11;

    // mstatus fields.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // width of the stored exception code in mcause.
    localparam int CAUSE_CODE_W = 4;

    // depth of the interrupt line synchronizer.
    localparam int SYNC_STAGES = 2;

endpackage

/* logic/trap_state_if.sv */
// trap state bundle from trap control to the CSR read mux.
interface trap_state_if import trap_pkg::*; ();

    priv_t prv;
    logic  mstatus_mie;
    logic  mstatus_mpie;
    priv_t mstatus_mpp;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;

    modport source (
        output prv, mstatus_mie, mstatus_mpie, mstatus_mpp, mepc, mcause, mtval
    );

    modport sink (
        input prv, mstatus_mie, mstatus_mpie, mstatus_mpp, mepc, mcause, mtval
    );

endinterface

/* logic/trap_unit.sv */
// trap and status unit top: machine mode traps, interrupts and CSRs for an RV32 core.
module trap_unit import trap_pkg::*; (
    input  logic      clk,
    input  logic      srstn,
    input  logic      ext_msip,
    input  logic      ext_mtip,
    input  logic      ext_meip,
    input  logic      int_mask,
    input  logic      trap_en,
    input  xlen_t     trap_epc,
    input  xlen_t     trap_cause,
    input  xlen_t     trap_val,
    input  logic      mret,
    input  logic      csr_wr,
    input  csr_addr_t csr_waddr,
    input  xlen_t     csr_wdata,
    input  csr_addr_t csr_raddr,
    output xlen_t     csr_rdata,
    output priv_t     prv,
    output logic      irq_trigger,
    output logic      wakeup,
    output xlen_t     cause,
    output xlen_t     tval,
    output xlen_t     trap_vec,
    output xlen_t     ret_epc,
    output logic      eret_en
);

logic [2:0]              mie_en;
logic [2:0]              mip_pend;
logic                    irq_any;
logic [CAUSE_CODE_W-1:0] irq_code;
xlen_t                   mtvec;

trap_state_if state_if ();

irq_select irq_select_i (
    .clk      (clk),
    .srstn    (srstn),
    .ext_msip (ext_msip),
    .ext_mtip (ext_mtip),
    .ext_meip (ext_meip),
    .mie_en   (mie_en),
    .mip_pend (mip_pend),
    .irq_m_en (),
    .irq_any  (irq_any),
    .irq_code (irq_code),
    .wakeup   (wakeup)
);

trap_ctrl trap_ctrl_i (
    .clk         (clk),
    .srstn       (srstn),
    .irq_any     (irq_any),
    .irq_code    (irq_code),
    .int_mask    (int_mask),
    .trap_en     (trap_en),
    .trap_epc    (trap_epc),
    .trap_cause  (trap_cause),
    .trap_val    (trap_val),
    .mret        (mret),
    .csr_wr      (csr_wr),
    .csr_waddr   (csr_waddr),
    .csr_wdata   (csr_wdata),
    .mtvec       (mtvec),
    .state       (state_if.source),
    .irq_trigger (irq_trigger),
    .cause       (cause),
    .tval        (tval),
    .trap_vec    (trap_vec),
    .ret_epc     (ret_epc),
    .eret_en     (eret_en)
);

csr_regs csr_regs_i (
    .clk       (clk),
    .srstn     (srstn),
    .csr_wr    (csr_wr),
    .csr_waddr (csr_waddr),
    .csr_wdata (csr_wdata),
    .csr_raddr (csr_raddr),
    .mip_pend  (mip_pend),
    .state     (state_if.sink),
    .mie_en    (mie_en),
    .mtvec     (mtvec),
    .csr_rdata (csr_rdata)
);

assign prv = state_if.prv;

endmodule
